// ==== interconnect_pkg.sv ====
package interconnect_pkg;

  // message is address over data
  localparam int MSG_W  = 18;
  localparam int DATA_W = 16;
  localparam int ADDR_W = 2;

  // destination decoded from the top message bits
  typedef enum logic [ADDR_W-1:0] {
    ADDR_XBAR_DATA = 2'd0,
    ADDR_XBAR_CTRL = 2'd1,
    ADDR_ECHO      = 2'd2,
    ADDR_DROP      = 2'd3
  } msg_addr_e;

  // return stream index, doubles as the response tag
  typedef enum logic [MSG_W-DATA_W-1:0] {
    SRC_DIRECT = 2'd0,
    SRC_FRAME  = 2'd1,
    SRC_ECHO   = 2'd2
  } ret_src_e;

  // response word, tag in 17:16 and data in 15:0
  typedef struct packed {
    ret_src_e          tag;
    logic [DATA_W-1:0] data;
  } resp_t;

  typedef enum logic [1:0] {IDLE, SHIFT, COMMIT} spi_state_e;

  typedef enum logic {FILL, DRAIN} frame_state_e;

endpackage

// ==== spi_minion.sv ====
`timescale 1ns/100ps

module spi_minion import interconnect_pkg::*; #(
  parameter int BIT_WIDTH = MSG_W
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cs,
  input  logic                 sclk,
  input  logic                 mosi,
  output logic                 miso,
  output logic                 minion_parity,
  output logic                 adapter_parity,
  output logic                 send_val,
  input  logic                 send_rdy,
  output logic [BIT_WIDTH-1:0] send_msg,
  input  logic                 recv_val,
  output logic                 recv_rdy,
  input  logic [BIT_WIDTH-1:0] recv_msg
);

  // two flag bits ahead of the payload
  localparam int FRAME_W = BIT_WIDTH + 2;

  spi_state_e           state_q;
  logic [2:0]           sclk_q;
  logic [2:0]           cs_q;
  logic [1:0]           mosi_q;
  logic                 sclk_rise;
  logic                 sclk_fall;
  logic                 cs_fall;
  logic                 cs_rise;
  logic [FRAME_W-1:0]   rx_q;
  logic [FRAME_W-1:0]   tx_q;
  logic                 snap_resp_val_q;
  logic                 snap_req_space_q;
  logic                 req_full_q;
  logic [BIT_WIDTH-1:0] req_data_q;
  logic                 resp_full_q;
  logic [BIT_WIDTH-1:0] resp_data_q;
  logic                 host_val;
  logic                 host_rdy;
  logic [BIT_WIDTH-1:0] host_payload;

  // 2-flop sync, third flop for edge detect
  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_q <= '0;
      cs_q   <= '1;
    end else begin
      sclk_q <= {sclk_q[1:0], sclk};
      cs_q   <= {cs_q[1:0], cs};
    end
  end

  assign sclk_rise = sclk_q[1] & ~sclk_q[2];
  assign sclk_fall = ~sclk_q[1] & sclk_q[2];
  assign cs_fall   = ~cs_q[1] & cs_q[2];
  assign cs_rise   = cs_q[1] & ~cs_q[2];

  // mosi flags then payload, MSB first
  assign host_val     = rx_q[FRAME_W-1];
  assign host_rdy     = rx_q[FRAME_W-2];
  assign host_payload = rx_q[BIT_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q          <= IDLE;
      tx_q             <= '0;
      snap_resp_val_q  <= 1'b0;
      snap_req_space_q <= 1'b0;
      req_full_q       <= 1'b0;
      resp_full_q      <= 1'b0;
      minion_parity    <= 1'b0;
      adapter_parity   <= 1'b0;
    end else begin
      // router took the request
      if (send_val && send_rdy) begin
        req_full_q <= 1'b0;
      end
      if (recv_val && recv_rdy) begin
        resp_full_q <= 1'b1;
      end
      case (state_q)
        IDLE: begin
          // snapshot flags and response for this frame
          if (cs_fall) begin
            snap_resp_val_q  <= resp_full_q;
            snap_req_space_q <= !req_full_q;
            tx_q    <= {resp_full_q, !req_full_q, resp_full_q ? resp_data_q : '0};
            state_q <= SHIFT;
          end
        end
        SHIFT: begin
          // next miso bit on falling sclk
          if (sclk_fall) begin
            tx_q <= {tx_q[FRAME_W-2:0], 1'b0};
          end
          if (cs_rise) begin
            state_q <= COMMIT;
          end
        end
        COMMIT: begin
          if (host_val && snap_req_space_q) begin
            req_full_q    <= 1'b1;
            minion_parity <= ^host_payload;
          end
          // host consumed the response
          if (host_rdy && snap_resp_val_q) begin
            resp_full_q    <= 1'b0;
            adapter_parity <= ^resp_data_q;
          end
          state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    mosi_q <= {mosi_q[0], mosi};
    // sample mosi aligned with the synced sclk
    if (state_q == SHIFT && sclk_rise) begin
      rx_q <= {rx_q[FRAME_W-2:0], mosi_q[1]};
    end
    if (state_q == COMMIT && host_val && snap_req_space_q) begin
      req_data_q <= host_payload;
    end
    if (recv_val && recv_rdy) begin
      resp_data_q <= recv_msg;
    end
  end

  assign miso     = tx_q[FRAME_W-1];
  assign send_val = req_full_q;
  assign send_msg = req_data_q;
  // one-deep response buffer
  assign recv_rdy = !resp_full_q;

endmodule

// ==== msg_router.sv ====
`timescale 1ns/100ps

module msg_router import interconnect_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             recv_val,
  output logic             recv_rdy,
  input  logic [MSG_W-1:0] recv_msg,
  output logic             send_val [3],
  input  logic             send_rdy [3],
  output logic [MSG_W-1:0] send_msg [3]
);

  msg_addr_e addr;

  // address in the top message bits
  assign addr = msg_addr_e'(recv_msg[MSG_W-1 -: ADDR_W]);

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      send_val[i] = 1'b0;
      send_msg[i] = recv_msg;
    end
    recv_rdy = 1'b0;
    case (addr)
      ADDR_XBAR_DATA: begin
        send_val[0] = recv_val;
        recv_rdy    = send_rdy[0];
      end
      ADDR_XBAR_CTRL: begin
        send_val[1] = recv_val;
        recv_rdy    = send_rdy[1];
      end
      ADDR_ECHO: begin
        send_val[2] = recv_val;
        recv_rdy    = send_rdy[2];
      end
      // drop address, always absorbed
      default: recv_rdy = 1'b1;
    endcase
  end

endmodule

// ==== blocking_crossbar.sv ====
`timescale 1ns/100ps

module blocking_crossbar import interconnect_pkg::*; #(
  parameter int N_OUTPUTS = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              recv_val,
  output logic              recv_rdy,
  input  logic [MSG_W-1:0]  recv_msg,
  output logic              send_val [N_OUTPUTS],
  input  logic              send_rdy [N_OUTPUTS],
  output logic [DATA_W-1:0] send_msg [N_OUTPUTS],
  input  logic              ctrl_val,
  output logic              ctrl_rdy,
  input  logic [MSG_W-1:0]  ctrl_msg
);

  localparam int SEL_W = (N_OUTPUTS > 1) ? $clog2(N_OUTPUTS) : 1;

  logic [SEL_W-1:0] sel_q;

  // select register, written by a control transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= '0;
    end else if (ctrl_val && ctrl_rdy) begin
      sel_q <= ctrl_msg[SEL_W-1:0];
    end
  end

  // select always writable
  assign ctrl_rdy = 1'b1;

  // only the selected output sees val, data field only
  always_comb begin
    for (int i = 0; i < N_OUTPUTS; i++) begin
      send_val[i] = recv_val && (sel_q == SEL_W'(i));
      send_msg[i] = recv_msg[DATA_W-1:0];
    end
  end

  // blocking, selected rdy only
  assign recv_rdy = send_rdy[sel_q];

endmodule

// ==== deserializer.sv ====
`timescale 1ns/100ps

module deserializer import interconnect_pkg::*; #(
  parameter int N_SAMPLES = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              recv_val,
  output logic              recv_rdy,
  input  logic [DATA_W-1:0] recv_msg,
  output logic              send_val,
  input  logic              send_rdy,
  output logic [DATA_W-1:0] send_msg [N_SAMPLES]
);

  localparam int CNT_W = (N_SAMPLES > 1) ? $clog2(N_SAMPLES) : 1;

  frame_state_e      state_q;
  logic [CNT_W-1:0]  count_q;
  logic [DATA_W-1:0] frame_q [N_SAMPLES];

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FILL;
      count_q <= '0;
    end else begin
      case (state_q)
        FILL: begin
          if (recv_val && recv_rdy) begin
            // last word closes the frame
            if (count_q == CNT_W'(N_SAMPLES - 1)) begin
              count_q <= '0;
              state_q <= DRAIN;
            end else begin
              count_q <= count_q + 1'b1;
            end
          end
        end
        DRAIN: begin
          if (send_rdy) begin
            state_q <= FILL;
          end
        end
        default: state_q <= FILL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      frame_q[count_q] <= recv_msg;
    end
  end

  // input blocked while a full frame waits
  assign recv_rdy = (state_q == FILL);
  assign send_val = (state_q == DRAIN);
  assign send_msg = frame_q;

endmodule

// ==== serializer.sv ====
`timescale 1ns/100ps

module serializer import interconnect_pkg::*; #(
  parameter int N_SAMPLES = 4
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              recv_val,
  output logic              recv_rdy,
  input  logic [DATA_W-1:0] recv_msg [N_SAMPLES],
  output logic              send_val,
  input  logic              send_rdy,
  output logic [DATA_W-1:0] send_msg
);

  localparam int IDX_W = (N_SAMPLES > 1) ? $clog2(N_SAMPLES) : 1;

  // fill is idle, drain is replay
  frame_state_e      state_q;
  logic [IDX_W-1:0]  idx_q;
  logic [DATA_W-1:0] frame_q [N_SAMPLES];

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FILL;
      idx_q   <= '0;
    end else begin
      case (state_q)
        FILL: begin
          if (recv_val && recv_rdy) begin
            idx_q   <= '0;
            state_q <= DRAIN;
          end
        end
        DRAIN: begin
          if (send_rdy) begin
            // back to idle after the last word
            if (idx_q == IDX_W'(N_SAMPLES - 1)) begin
              state_q <= FILL;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
        default: state_q <= FILL;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      frame_q <= recv_msg;
    end
  end

  assign recv_rdy = (state_q == FILL);
  assign send_val = (state_q == DRAIN);
  assign send_msg = frame_q[idx_q];

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/100ps

module rr_arbiter import interconnect_pkg::*; #(
  parameter int N_INPUTS = 3
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              recv_val [N_INPUTS],
  output logic              recv_rdy [N_INPUTS],
  input  logic [DATA_W-1:0] recv_msg [N_INPUTS],
  output logic              send_val,
  input  logic              send_rdy,
  output logic [MSG_W-1:0]  send_msg
);

  localparam int IDX_W = (N_INPUTS > 1) ? $clog2(N_INPUTS) : 1;

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] lock_idx_q;
  logic             lock_q;
  logic [IDX_W-1:0] grant;
  logic             found;
  resp_t            resp;

  // first valid at or after the pointer
  always_comb begin
    int cand;
    found = 1'b0;
    grant = ptr_q;
    cand  = 0;
    if (lock_q) begin
      // stalled winner keeps the grant
      found = 1'b1;
      grant = lock_idx_q;
    end else begin
      for (int k = 0; k < N_INPUTS; k++) begin
        cand = (int'(ptr_q) + k) % N_INPUTS;
        if (!found && recv_val[cand]) begin
          found = 1'b1;
          grant = IDX_W'(cand);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q      <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (send_val && send_rdy) begin
      // pointer moves past the winner
      ptr_q  <= (grant == IDX_W'(N_INPUTS - 1)) ? '0 : grant + 1'b1;
      lock_q <= 1'b0;
    end else if (send_val) begin
      lock_q     <= 1'b1;
      lock_idx_q <= grant;
    end
  end

  always_comb begin
    for (int i = 0; i < N_INPUTS; i++) begin
      recv_rdy[i] = send_rdy && found && (grant == IDX_W'(i));
    end
  end

  // source index as tag over data
  assign resp.tag  = ret_src_e'(grant);
  assign resp.data = recv_msg[grant];
  assign send_val  = found;
  assign send_msg  = resp;

endmodule

// ==== interconnect_top.sv ====
`timescale 1ns/100ps

module interconnect_top import interconnect_pkg::*; #(
  parameter int N_SAMPLES = 4,
  parameter int SPI_BITS  = MSG_W
) (
  input  logic clk,
  input  logic rst,
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output logic minion_parity,
  output logic adapter_parity
);

  logic                spi_send_val;
  logic                spi_send_rdy;
  logic [SPI_BITS-1:0] spi_send_msg;
  logic                spi_recv_val;
  logic                spi_recv_rdy;
  logic [SPI_BITS-1:0] spi_recv_msg;
  logic                router_val [3];
  logic                router_rdy [3];
  logic [MSG_W-1:0]    router_msg [3];
  logic                xbar_val [2];
  logic                xbar_rdy [2];
  logic [DATA_W-1:0]   xbar_msg [2];
  logic                frame_val;
  logic                frame_rdy;
  logic [DATA_W-1:0]   frame_msg [N_SAMPLES];
  logic                arb_val [3];
  logic                arb_rdy [3];
  logic [DATA_W-1:0]   arb_msg [3];

  spi_minion #(.BIT_WIDTH(SPI_BITS)) spi_minion_inst (
    .clk(clk), .rst(rst), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .minion_parity(minion_parity), .adapter_parity(adapter_parity),
    .send_val(spi_send_val), .send_rdy(spi_send_rdy), .send_msg(spi_send_msg),
    .recv_val(spi_recv_val), .recv_rdy(spi_recv_rdy), .recv_msg(spi_recv_msg)
  );

  msg_router msg_router_inst (
    .clk(clk), .rst(rst),
    .recv_val(spi_send_val), .recv_rdy(spi_send_rdy), .recv_msg(spi_send_msg),
    .send_val(router_val), .send_rdy(router_rdy), .send_msg(router_msg)
  );

  // address 0 data, address 1 select
  blocking_crossbar #(.N_OUTPUTS(2)) blocking_crossbar_inst (
    .clk(clk), .rst(rst),
    .recv_val(router_val[0]), .recv_rdy(router_rdy[0]), .recv_msg(router_msg[0]),
    .send_val(xbar_val), .send_rdy(xbar_rdy), .send_msg(xbar_msg),
    .ctrl_val(router_val[1]), .ctrl_rdy(router_rdy[1]), .ctrl_msg(router_msg[1])
  );

  // frame path on crossbar output 1
  deserializer #(.N_SAMPLES(N_SAMPLES)) deserializer_inst (
    .clk(clk), .rst(rst),
    .recv_val(xbar_val[1]), .recv_rdy(xbar_rdy[1]), .recv_msg(xbar_msg[1]),
    .send_val(frame_val), .send_rdy(frame_rdy), .send_msg(frame_msg)
  );

  serializer #(.N_SAMPLES(N_SAMPLES)) serializer_inst (
    .clk(clk), .rst(rst),
    .recv_val(frame_val), .recv_rdy(frame_rdy), .recv_msg(frame_msg),
    .send_val(arb_val[SRC_FRAME]), .send_rdy(arb_rdy[SRC_FRAME]),
    .send_msg(arb_msg[SRC_FRAME])
  );

  // direct return from crossbar output 0
  assign arb_val[SRC_DIRECT] = xbar_val[0];
  assign arb_msg[SRC_DIRECT] = xbar_msg[0];
  assign xbar_rdy[0]         = arb_rdy[SRC_DIRECT];

  // echo skips the crossbar
  assign arb_val[SRC_ECHO] = router_val[2];
  assign arb_msg[SRC_ECHO] = router_msg[2][DATA_W-1:0];
  assign router_rdy[2]     = arb_rdy[SRC_ECHO];

  rr_arbiter #(.N_INPUTS(3)) rr_arbiter_inst (
    .clk(clk), .rst(rst),
    .recv_val(arb_val), .recv_rdy(arb_rdy), .recv_msg(arb_msg),
    .send_val(spi_recv_val), .send_rdy(spi_recv_rdy), .send_msg(spi_recv_msg)
  );

endmodule

// ==== interconnect_sva.sv ====
`timescale 1ns/100ps

module interconnect_sva import interconnect_pkg::*; (
  input logic             clk,
  input logic             rst,
  input logic             cs,
  input logic             miso,
  input logic             req_val,
  input logic             req_rdy,
  input logic [MSG_W-1:0] req_msg,
  input logic             resp_val,
  input logic             resp_rdy,
  input logic [MSG_W-1:0] resp_msg,
  input logic             frame_val,
  input logic             frame_rdy,
  input logic             route_val [3]
);

  // minion request buffer holds until the router takes it
  req_hold_a: assert property (@(posedge clk) disable iff (rst)
    req_val && !req_rdy |=> req_val && $stable(req_msg))
    else $error("request stream changed before its transfer");

  // arbiter output held while the minion is full
  resp_hold_a: assert property (@(posedge clk) disable iff (rst)
    resp_val && !resp_rdy |=> resp_val && $stable(resp_msg))
    else $error("response stream changed before its transfer");

  frame_hold_a: assert property (@(posedge clk) disable iff (rst)
    frame_val && !frame_rdy |=> frame_val)
    else $error("deserializer dropped a frame before transfer");

  route_onehot_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0({route_val[0], route_val[1], route_val[2]}))
    else $error("more than one router output valid");

  // no shifting between frames
  miso_idle_a: assert property (@(posedge clk) disable iff (rst)
    cs && $past(cs) |-> $stable(miso))
    else $error("miso moved while cs was high");

endmodule

bind interconnect_top interconnect_sva interconnect_sva_inst (
  .clk(clk), .rst(rst), .cs(cs), .miso(miso),
  .req_val(spi_send_val), .req_rdy(spi_send_rdy), .req_msg(spi_send_msg),
  .resp_val(spi_recv_val), .resp_rdy(spi_recv_rdy), .resp_msg(spi_recv_msg),
  .frame_val(frame_val), .frame_rdy(frame_rdy),
  .route_val(router_val)
);

// ==== tb_interconnect.sv ====
`timescale 1ns/100ps

module tb_interconnect import interconnect_pkg::*; ();

  localparam int N_SAMPLES  = 4;
  localparam int FRAME_BITS = MSG_W + 2;
  // clk cycles per sclk phase
  localparam int HALF       = 4;
  // about 160 frames at 177 cycles each plus margin
  localparam int CYCLE_LIMIT = 60000;
  localparam logic [31:0] SEED = 32'h945f00a9;

  logic clk = 1'b0;
  logic rst;
  logic cs;
  logic sclk;
  logic mosi;
  logic miso;
  logic minion_parity;
  logic adapter_parity;

  logic [31:0]       lfsr_q;
  logic              sel_model;
  logic [DATA_W-1:0] direct_q [$];
  logic [DATA_W-1:0] frame_q [$];
  logic [DATA_W-1:0] pend_q [$];
  logic [DATA_W-1:0] echo_q [$];
  logic              exp_minion_par;
  logic              exp_adapter_par;
  int                cycles = 0;
  int                refused;

  interconnect_top #(.N_SAMPLES(N_SAMPLES), .SPI_BITS(MSG_W)) interconnect_top_inst (
    .clk(clk), .rst(rst), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .minion_parity(minion_parity), .adapter_parity(adapter_parity)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run went past %0d clock cycles", CYCLE_LIMIT);
      stop_run();
    end
  end

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "stopped at first failing check");
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    assert (got === want) else begin
      $display("ERR %0t %s got %0h expected %0h", $time, name, got, want);
      stop_run();
    end
  endtask

  task automatic ensure(input logic cond, input string what);
    assert (cond) else begin
      $display("%0t %s", $time, what);
      stop_run();
    end
  endtask

  // 20-bit frame with mosi set in the sclk low phase and miso read at sclk rise
  task automatic spi_frame(input logic hv, input logic hr, input logic [MSG_W-1:0] pay,
                           output logic rv, output logic rs, output logic [MSG_W-1:0] rsp);
    logic [FRAME_BITS-1:0] tx;
    logic [FRAME_BITS-1:0] rx;
    tx = {hv, hr, pay};
    rx = '0;
    @(negedge clk);
    cs = 1'b0;
    // room for the cs-fall snapshot
    repeat (HALF) @(negedge clk);
    for (int i = FRAME_BITS - 1; i >= 0; i--) begin
      mosi = tx[i];
      sclk = 1'b0;
      repeat (HALF) @(negedge clk);
      sclk = 1'b1;
      rx[i] = miso;
      repeat (HALF) @(negedge clk);
    end
    sclk = 1'b0;
    repeat (HALF) @(negedge clk);
    cs = 1'b1;
    // commit goes through the cs synchronizer
    repeat (2 * HALF) @(negedge clk);
    {rv, rs, rsp} = rx;
  endtask

  task automatic model_request(input logic [MSG_W-1:0] pay);
    logic [DATA_W-1:0] d;
    d = pay[DATA_W-1:0];
    case (msg_addr_e'(pay[MSG_W-1 -: ADDR_W]))
      ADDR_XBAR_DATA: begin
        if (sel_model) begin
          pend_q.push_back(d);
          // frame path only answers with whole frames
          if (pend_q.size() == N_SAMPLES) begin
            while (pend_q.size() > 0) begin
              frame_q.push_back(pend_q.pop_front());
            end
          end
        end else begin
          direct_q.push_back(d);
        end
      end
      ADDR_XBAR_CTRL: sel_model = pay[0];
      ADDR_ECHO: begin
        echo_q.push_back(d);
      end
      // drop address gives no response
      default: ;
    endcase
  endtask

  task automatic score_response(input logic [MSG_W-1:0] rsp);
    logic [DATA_W-1:0] want;
    logic [1:0]        tag;
    tag = rsp[MSG_W-1 -: 2];
    want = '0;
    case (tag)
      SRC_DIRECT: begin
        ensure(direct_q.size() > 0, "direct response arrived with none expected");
        want = direct_q.pop_front();
      end
      SRC_FRAME: begin
        ensure(frame_q.size() > 0, "frame response arrived before a full frame");
        want = frame_q.pop_front();
      end
      SRC_ECHO: begin
        ensure(echo_q.size() > 0, "echo response arrived with none expected");
        want = echo_q.pop_front();
      end
      default: ensure(1'b0, "response carries an unused source tag");
    endcase
    compare_value("miso data", rsp[DATA_W-1:0], want);
  endtask

  // one frame then model update and parity checks
  task automatic do_frame(input logic hv, input logic hr, input logic [MSG_W-1:0] pay,
                          output logic accepted);
    logic             rv;
    logic             rs;
    logic [MSG_W-1:0] rsp;
    spi_frame(hv, hr, pay, rv, rs, rsp);
    accepted = hv && rs;
    if (hv && !rs) begin
      refused++;
    end
    if (hr && rv) begin
      score_response(rsp);
      exp_adapter_par = ^rsp;
    end
    if (accepted) begin
      model_request(pay);
      exp_minion_par = ^pay;
    end
    compare_value("minion_parity", minion_parity, exp_minion_par);
    compare_value("adapter_parity", adapter_parity, exp_adapter_par);
  endtask

  // retry until the request buffer takes it
  task automatic send_req(input logic [MSG_W-1:0] pay);
    logic ok;
    ok = 1'b0;
    while (!ok) begin
      do_frame(1'b1, 1'b1, pay, ok);
    end
  endtask

  initial begin
    logic             rv;
    logic             rs;
    logic             ok;
    logic             hv;
    logic             hr;
    logic [MSG_W-1:0] rsp;
    logic [MSG_W-1:0] pay;
    int               n;
    lfsr_q          = SEED;
    sel_model       = 1'b0;
    exp_minion_par  = 1'b0;
    exp_adapter_par = 1'b0;
    refused         = 0;
    rst  = 1'b1;
    cs   = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    repeat (4) @(negedge clk);

    // empty frame right after reset
    spi_frame(1'b0, 1'b0, '0, rv, rs, rsp);
    compare_value("resp_val", rv, 1'b0);
    compare_value("req_space", rs, 1'b1);
    compare_value("miso payload", rsp, '0);
    compare_value("minion_parity", minion_parity, 1'b0);
    compare_value("adapter_parity", adapter_parity, 1'b0);

    // echoes
    repeat (20) send_req({ADDR_ECHO, DATA_W'(rand_bits(DATA_W))});

    // select 0 returns direct with drops in between
    repeat (6) send_req({ADDR_XBAR_DATA, DATA_W'(rand_bits(DATA_W))});
    repeat (3) send_req({ADDR_DROP, DATA_W'(rand_bits(DATA_W))});
    send_req({ADDR_XBAR_CTRL, 16'h0001});
    repeat (3 * N_SAMPLES) send_req({ADDR_XBAR_DATA, DATA_W'(rand_bits(DATA_W))});

    // host holds responses so requests back up
    refused = 0;
    repeat (10) do_frame(1'b1, 1'b0, {ADDR_ECHO, DATA_W'(rand_bits(DATA_W))}, ok);
    ensure(refused > 0, "no request was refused while responses were held back");

    // random mix of addresses and flags
    repeat (60) begin
      hv  = (rand_bits(2) != 0);
      hr  = (rand_bits(2) != 0);
      pay = MSG_W'(rand_bits(MSG_W));
      do_frame(hv, hr, pay, ok);
    end

    // poll until every expected word is back
    n = 0;
    while ((direct_q.size() + frame_q.size() + echo_q.size()) > 0 && n < 40) begin
      do_frame(1'b0, 1'b1, '0, ok);
      n++;
    end
    // extra responses would hit an empty queue here
    repeat (4) do_frame(1'b0, 1'b1, '0, ok);
    ensure((direct_q.size() + frame_q.size() + echo_q.size()) == 0,
           "responses still missing after draining");

    $display("No errors");
    $finish;
  end

endmodule

// ==== sources.f ====
interconnect_pkg.sv
spi_minion.sv
msg_router.sv
blocking_crossbar.sv
deserializer.sv
serializer.sv
rr_arbiter.sv
interconnect_top.sv
interconnect_sva.sv
tb_interconnect.sv

// ==== Bender.yml ====
package:
  name: interconnect

sources:
  - interconnect_pkg.sv
  - spi_minion.sv
  - msg_router.sv
  - blocking_crossbar.sv
  - deserializer.sv
  - serializer.sv
  - rr_arbiter.sv
  - interconnect_top.sv
  - target: test
    files:
      - interconnect_sva.sv
      - tb_interconnect.sv
